// File: common/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    localparam int IMEM_AW = 8;                 // word address, 256 words
    localparam int FB_DEPTH = 16;
    localparam int FB_PTR_W = $clog2(FB_DEPTH);

    // direct branch opcodes, instr[31:26]
    localparam logic [5:0] BR_OP_LO = 6'h14;
    localparam logic [5:0] BR_OP_HI = 6'h17;

    localparam logic [5:0] EXC_ADEF = 6'h08;    // misaligned fetch address

    typedef struct packed {
        logic        is_branch;
        logic [31:0] target;
    } predec_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        predec_t     pre;
        logic        excp;
        logic [5:0]  excp_code;
    } fb_entry_t;

    // one fetch group, slot 1 only meaningful when pair is set
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr0;
        logic [31:0] instr1;
        logic        pair;
        logic        excp;
    } fetch_group_t;

endpackage

`default_nettype wire

// File: compile.f
common/frontend_pkg.sv
verilog/pc_gen.sv
verilog/fetch_stage.sv
verilog/predecode.sv
fetch_buffer/fetch_buffer.sv
verilog/frontend_top.sv
testbench/frontend_tb.sv

// File: fetch_buffer/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    input  frontend_pkg::fb_entry_t in0,
    input  frontend_pkg::fb_entry_t in1,
    input  logic [1:0]              in_cnt,
    input  logic [1:0]              deq_cnt,
    output logic                    in_ready,
    output frontend_pkg::fb_entry_t out0,
    output frontend_pkg::fb_entry_t out1,
    output logic                    out_valid0,
    output logic                    out_valid1
);
    import frontend_pkg::*;

    fb_entry_t buf_mem [0:FB_DEPTH-1];

    logic [FB_PTR_W-1:0] head;
    logic [FB_PTR_W-1:0] tail;
    logic [FB_PTR_W-1:0] head_nxt;
    logic [FB_PTR_W-1:0] tail_nxt;
    logic [FB_PTR_W:0]   count;
    logic [FB_PTR_W:0]   push_n;
    logic [FB_PTR_W:0]   pop_n;
    logic                push;

    assign head_nxt = head + 1'b1;   // wraps, depth is a power of two
    assign tail_nxt = tail + 1'b1;

    // room for a full pair, so a group never has to be split
    assign in_ready = count <= (FB_PTR_W+1)'(FB_DEPTH - 2);
    assign push     = in_valid && in_ready && !flush;

    assign out_valid0 = |count;
    assign out_valid1 = |count[FB_PTR_W:1];
    assign out0       = buf_mem[head];  // oldest
    assign out1       = buf_mem[head_nxt];

    always_comb begin
        if (push) begin
            push_n = {{(FB_PTR_W-1){1'b0}}, in_cnt};
        end else begin
            push_n = '0;
        end
    end

    // retire no more than what is actually shown to decode
    always_comb begin
        case (deq_cnt)
            2'd0: pop_n = '0;
            2'd1: pop_n = {{FB_PTR_W{1'b0}}, out_valid0};
            default: begin
                if (out_valid1) begin
                    pop_n = (FB_PTR_W+1)'(2);
                end else begin
                    pop_n = {{FB_PTR_W{1'b0}}, out_valid0};
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[tail] <= in0;
            if (in_cnt == 2'd2) begin
                buf_mem[tail_nxt] <= in1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + pop_n[FB_PTR_W-1:0];
            tail  <= tail + push_n[FB_PTR_W-1:0];
            count <= count + push_n - pop_n;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=frontend_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal --top-module "$TOP" \
    -f compile.f -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: testbench/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
    import frontend_pkg::*;

    localparam int LOAD_CYCLES   = 2**IMEM_AW;
    localparam int STREAM_CYCLES = 200;
    localparam int BP_CYCLES     = 300;
    localparam int REDIR_CYCLES  = 60;
    localparam int TEST_CYCLES   = 3 + LOAD_CYCLES + STREAM_CYCLES + BP_CYCLES
                                   + 2 * (REDIR_CYCLES + 1) + 16;

    localparam logic [31:0] TARGET_ODD = 32'h0000_0134;   // pc[2] set
    localparam logic [31:0] TARGET_MIS = 32'h0000_020a;   // pc[1:0] nonzero

    logic               clk;
    logic               rst;
    logic               load_we;
    logic [IMEM_AW-1:0] load_addr;
    logic [31:0]        load_data;
    logic               redirect_valid;
    logic [31:0]        redirect_pc;
    logic [1:0]         deq_cnt;
    fb_entry_t          out0;
    fb_entry_t          out1;
    logic               out_valid0;
    logic               out_valid1;

    logic [31:0] model_mem [0:2**IMEM_AW-1];
    logic [31:0] lcg_state;
    string       test_name;
    logic        rand_pop;

    // checker state
    logic [31:0] exp_pc;
    logic        first_after_flush;
    logic        wait_first;
    int          since_flush;
    int          pop_total = 0;
    int          branch_total = 0;
    int          pair_total = 0;

    frontend_top frontend_top_i (
        .clk            (clk),
        .rst            (rst),
        .load_we        (load_we),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .deq_cnt        (deq_cnt),
        .out0           (out0),
        .out1           (out1),
        .out_valid0     (out_valid0),
        .out_valid1     (out_valid1)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // pc of the entry that follows
    function automatic logic [31:0] next_entry_pc(input logic [31:0] pc);
        if (pc[2]) begin
            return {pc[31:3] + 29'd1, 3'b000};
        end
        return pc + 32'd4;
    endfunction

    function automatic fb_entry_t expected_entry(input logic [31:0] pc, input logic first);
        fb_entry_t   e;
        logic [31:0] word;
        logic [31:0] offs;
        word = model_mem[pc[IMEM_AW+1:2]];
        offs = {{14{word[25]}}, word[25:10], 2'b00};
        e.pc            = pc;
        e.instr         = word;
        e.pre.is_branch = (word[31:26] >= BR_OP_LO) && (word[31:26] <= BR_OP_HI);
        e.pre.target    = pc + offs;
        e.excp          = first && (pc[1:0] != 2'b00);   // only the group's first slot
        e.excp_code     = e.excp ? EXC_ADEF : 6'd0;
        return e;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
        if (exp_v !== act_v) begin
            fail_run($sformatf("ERR %s %s: expected %h, actual %h",
                               test_name, what, exp_v, act_v));
        end
    endtask

    always @(posedge clk) begin
        fb_entry_t exp_e;
        fb_entry_t act_e;
        int        n;
        if (rst || redirect_valid) begin
            exp_pc            = rst ? RESET_PC : redirect_pc;
            first_after_flush = 1'b1;
            wait_first        = 1'b1;
            since_flush       = 0;
        end else begin
            since_flush = since_flush + 1;
            check_value("valid order", 128'd0, {127'd0, out_valid1 && !out_valid0});
            if (wait_first && out_valid0) begin
                check_value("first entry latency", 128'd3, 128'(since_flush));
                wait_first = 1'b0;
            end
            n = int'(deq_cnt);
            if (n == 2) begin
                pair_total = pair_total + 1;
            end
            for (int k = 0; k < n; k++) begin
                exp_e = expected_entry(exp_pc, first_after_flush);
                act_e = (k == 0) ? out0 : out1;
                check_value("entry", {24'd0, exp_e}, {24'd0, act_e});
                if (exp_e.pre.is_branch) begin
                    branch_total = branch_total + 1;
                end
                pop_total         = pop_total + 1;
                exp_pc            = next_entry_pc(exp_pc);
                first_after_flush = 1'b0;
            end
        end
    end

    // decode pop count capped at what is shown
    task automatic pick_pop();
        int avail;
        avail = out_valid1 ? 2 : (out_valid0 ? 1 : 0);
        if (rand_pop) begin
            lcg_state = lcg_next(lcg_state);
            deq_cnt   = 2'(int'(lcg_state[17:16]) % (avail + 1));
        end else begin
            deq_cnt = 2'(avail);
        end
    endtask

    task automatic load_program();
        logic [31:0] word;
        for (int a = 0; a < LOAD_CYCLES; a++) begin
            lcg_state = lcg_next(lcg_state);
            word      = lcg_state;
            if (lcg_state[31:30] == 2'b00) begin
                word[31:26] = {4'b0101, lcg_state[13:12]};   // branch opcode range
            end
            model_mem[a] = word;
            load_we      = 1'b1;
            load_addr    = IMEM_AW'(a);
            load_data    = word;
            @(negedge clk);
        end
        load_we = 1'b0;
    endtask

    task automatic run_phase(input string name, input int cycles, input logic random_mode);
        int start_pops;
        test_name  = name;
        rand_pop   = random_mode;
        start_pops = pop_total;
        repeat (cycles) begin
            pick_pop();
            @(negedge clk);
        end
        if (pop_total == start_pops) begin
            fail_run({"no entries reached decode during ", name});
        end
    endtask

    task automatic redirect_to(input string name, input logic [31:0] target);
        test_name      = name;
        redirect_valid = 1'b1;
        redirect_pc    = target;
        deq_cnt        = 2'd0;
        @(negedge clk);
        redirect_valid = 1'b0;
        run_phase(name, REDIR_CYCLES, 1'b0);
    endtask

    initial begin
        rst            = 1'b1;
        load_we        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        redirect_valid = 1'b1;   // fetch held while the program loads
        redirect_pc    = RESET_PC;
        deq_cnt        = 2'd0;
        test_name      = "reset";
        rand_pop       = 1'b0;
        lcg_state      = 32'h68a0_5b1a;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        load_program();
        redirect_valid = 1'b0;
        run_phase("reset_stream", STREAM_CYCLES, 1'b0);
        run_phase("backpressure", BP_CYCLES, 1'b1);
        redirect_to("redirect_odd", TARGET_ODD);
        redirect_to("redirect_misaligned", TARGET_MIS);
        if (branch_total == 0) begin
            fail_run("no branch instruction reached decode");
        end else if (pair_total == 0) begin
            fail_run("decode never received two entries in one cycle");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    initial begin
        #(TEST_CYCLES * 4 * 8);
        fail_run("simulation hung and was stopped by the watchdog");
    end

endmodule

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               load_we,
    input  logic [frontend_pkg::IMEM_AW-1:0]   load_addr,
    input  logic [31:0]                        load_data,
    input  logic [31:0]                        fetch_pc,
    input  logic                               fetch_req,
    input  logic                               flush,
    input  logic                               in_ready,
    output logic                               advance,
    output frontend_pkg::fetch_group_t         group,
    output logic                               group_valid
);
    import frontend_pkg::*;

    // memory split into even and odd words so a group reads both at once
    logic [31:0] bank_even [0:2**(IMEM_AW-1)-1];
    logic [31:0] bank_odd  [0:2**(IMEM_AW-1)-1];

    logic [IMEM_AW-2:0] grp_idx;
    logic [31:0]        word_even;
    logic [31:0]        word_odd;

    assign grp_idx   = fetch_pc[IMEM_AW+1:3];   // 8-byte aligned group
    assign word_even = bank_even[grp_idx];
    assign word_odd  = bank_odd[grp_idx];

    // take a new group when empty or when the held one drains this edge
    assign advance = fetch_req && (!group_valid || in_ready);

    always_ff @(posedge clk) begin
        if (load_we) begin
            if (load_addr[0]) begin
                bank_odd[load_addr[IMEM_AW-1:1]] <= load_data;
            end else begin
                bank_even[load_addr[IMEM_AW-1:1]] <= load_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            group.pc     <= fetch_pc;
            group.instr0 <= fetch_pc[2] ? word_odd : word_even;
            group.instr1 <= word_odd;
            group.pair   <= !fetch_pc[2];
            group.excp   <= |fetch_pc[1:0];     // ADEF, fetch goes on
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            group_valid <= 1'b0;                // kills the in-flight group
        end else if (advance) begin
            group_valid <= 1'b1;
        end else if (in_ready) begin
            group_valid <= 1'b0;                // drained, nothing new
        end
    end

endmodule

`default_nettype wire

// File: verilog/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_we,
    input  logic [frontend_pkg::IMEM_AW-1:0] load_addr,
    input  logic [31:0]                      load_data,
    input  logic                             redirect_valid,
    input  logic [31:0]                      redirect_pc,
    input  logic [1:0]                       deq_cnt,
    output frontend_pkg::fb_entry_t          out0,
    output frontend_pkg::fb_entry_t          out1,
    output logic                             out_valid0,
    output logic                             out_valid1
);
    import frontend_pkg::*;

    logic [31:0]  fetch_pc;
    logic         fetch_req;
    logic         advance;
    fetch_group_t group;
    logic         group_valid;
    fb_entry_t    in0;
    fb_entry_t    in1;
    logic [1:0]   in_cnt;
    logic         in_ready;

    pc_gen pc_gen_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .advance        (advance),
        .fetch_pc       (fetch_pc),
        .fetch_req      (fetch_req)
    );

    fetch_stage fetch_stage_i (
        .clk         (clk),
        .rst         (rst),
        .load_we     (load_we),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_pc    (fetch_pc),
        .fetch_req   (fetch_req),
        .flush       (redirect_valid),  // redirect flushes the front end
        .in_ready    (in_ready),
        .advance     (advance),
        .group       (group),
        .group_valid (group_valid)
    );

    predecode predecode_i (
        .group  (group),
        .in0    (in0),
        .in1    (in1),
        .in_cnt (in_cnt)
    );

    fetch_buffer fetch_buffer_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (redirect_valid),
        .in_valid   (group_valid),
        .in0        (in0),
        .in1        (in1),
        .in_cnt     (in_cnt),
        .deq_cnt    (deq_cnt),
        .in_ready   (in_ready),
        .out0       (out0),
        .out1       (out1),
        .out_valid0 (out_valid0),
        .out_valid1 (out_valid1)
    );

endmodule

`default_nettype wire

// File: verilog/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        advance,
    output logic [31:0] fetch_pc,
    output logic        fetch_req
);
    import frontend_pkg::*;

    logic [31:0] next_group_pc;

    // start of the following 8-byte group
    // aligned pc: +8 when pc[2] is 0, +4 when pc[2] is 1
    // a misaligned pc falls back onto the group grid here
    assign next_group_pc = {fetch_pc[31:3] + 29'd1, 3'b000};

    assign fetch_req = !rst && !redirect_valid;   // no request while held

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= RESET_PC;
        end else if (redirect_valid) begin
            fetch_pc <= redirect_pc;
        end else if (advance) begin
            fetch_pc <= next_group_pc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/predecode.sv
`timescale 1ns/1ps
`default_nettype none

module predecode (
    input  frontend_pkg::fetch_group_t group,
    output frontend_pkg::fb_entry_t    in0,
    output frontend_pkg::fb_entry_t    in1,
    output logic [1:0]                 in_cnt
);
    import frontend_pkg::*;

    logic [31:0] slot1_pc;

    // builds one buffer entry from a slot pc and its instruction word
    function automatic fb_entry_t make_entry(
        input logic [31:0] pc,
        input logic [31:0] instr,
        input logic        excp
    );
        fb_entry_t  e;
        logic [5:0] op;
        op = instr[31:26];
        e.pc    = pc;
        e.instr = instr;
        e.pre.is_branch = (op >= BR_OP_LO) && (op <= BR_OP_HI);
        // offs16 in instr[25:10], word offset
        e.pre.target = pc + {{14{instr[25]}}, instr[25:10], 2'b00};
        e.excp      = excp;
        e.excp_code = excp ? EXC_ADEF : 6'd0;
        return e;
    endfunction

    assign slot1_pc = group.pc + 32'd4;

    assign in0    = make_entry(group.pc, group.instr0, group.excp);
    assign in1    = make_entry(slot1_pc, group.instr1, 1'b0);   // excp only on slot 0
    assign in_cnt = group.pair ? 2'd2 : 2'd1;

endmodule

`default_nettype wire
